// File: design/conv_pkg.sv
`default_nettype none

package conv_pkg;

	// ----------------------------------------
	// geometry
	// ----------------------------------------
	localparam int K = 3;
	localparam int MIN_IMG = 3;
	localparam int MAX_IMG_DEFAULT = 8;

	// ----------------------------------------
	// data words
	// ----------------------------------------
	typedef logic signed [7:0] pix_t;
	typedef logic signed [7:0] coef_t;
	typedef logic signed [15:0] prod_t;

	// sum of one kernel row
	typedef logic signed [17:0] row_sum_t;

	// sum of the full 3x3 window
	typedef logic signed [19:0] acc_t;

	typedef logic signed [15:0] result_t;

	// image size, row or column
	typedef logic [3:0] size_t;

	// ----------------------------------------
	// activation
	// ----------------------------------------
	localparam int SAT_MAX = 32767;

	// negative results are scaled by 1/LEAK_DIV in act mode 1
	localparam int LEAK_DIV = 10;

endpackage

`default_nettype wire

// File: design/conv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl #(
	parameter int MAX_IMG = conv_pkg::MAX_IMG_DEFAULT,
	localparam int ADDR_W = $clog2(MAX_IMG * MAX_IMG)
) (
	input  logic clk,
	input  logic rst_n,
	input  logic filter_valid,
	input  logic image_valid,
	input  conv_pkg::size_t image_size,
	input  logic pad_mode,
	input  logic act_mode,
	input  conv_pkg::pix_t in_data,
	output logic wr_en,
	output logic [ADDR_W-1:0] wr_addr,
	output logic scan_en,
	output conv_pkg::size_t scan_row,
	output conv_pkg::size_t scan_col,
	output conv_pkg::coef_t [conv_pkg::K-1:0][conv_pkg::K-1:0] row_coef,
	output conv_pkg::size_t img_size,
	output logic pad_sel,
	output logic act_sel
);

	import conv_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_KLOAD, ST_SCAN} state_t;

	state_t state;
	logic [1:0] k_row;
	logic [1:0] k_col;
	logic [1:0] k_row_sel;
	logic [1:0] k_col_sel;
	size_t row_cnt;
	size_t col_cnt;
	logic last_col;
	logic last_pos;
	logic last_coef;
	logic pos_step;

	assign last_col = (col_cnt == img_size - 1'b1);
	assign last_pos = last_col && (row_cnt == img_size - 1'b1);
	assign last_coef = (k_row == K - 1) && (k_col == K - 1);

	// frame write while pixels stream in, then one position per cycle
	assign wr_en = image_valid && (state == ST_IDLE);
	assign wr_addr = ADDR_W'(row_cnt * MAX_IMG + col_cnt);
	assign scan_en = (state == ST_SCAN);
	assign scan_row = row_cnt;
	assign scan_col = col_cnt;
	assign pos_step = wr_en || scan_en;

	// ----------------------------------------
	// FSM and settings
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			k_row <= '0;
			k_col <= '0;
			img_size <= size_t'(MIN_IMG);
			pad_sel <= 1'b0;
			act_sel <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (filter_valid) begin
						img_size <= image_size;
						pad_sel <= pad_mode;
						act_sel <= act_mode;
						k_row <= '0;
						k_col <= 2'd1;
						state <= ST_KLOAD;
					end else if (image_valid && last_pos) begin
						state <= ST_SCAN;
					end
				end
				ST_KLOAD: begin
					if (filter_valid) begin
						if (k_col == K - 1) begin
							k_col <= '0;
							k_row <= k_row + 1'b1;
						end else begin
							k_col <= k_col + 1'b1;
						end
						if (last_coef) begin
							state <= ST_IDLE;
						end
					end
				end
				ST_SCAN: begin
					if (last_pos) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// shared raster counter, wraps to 0,0 after the last position
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_cnt <= '0;
			col_cnt <= '0;
		end else if (pos_step) begin
			if (last_col) begin
				col_cnt <= '0;
				row_cnt <= last_pos ? '0 : row_cnt + 1'b1;
			end else begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	// first coefficient arrives while still idle
	assign k_row_sel = (state == ST_KLOAD) ? k_row : 2'd0;
	assign k_col_sel = (state == ST_KLOAD) ? k_col : 2'd0;

	always_ff @(posedge clk) begin
		if (filter_valid && state != ST_SCAN) begin
			row_coef[k_row_sel][k_col_sel] <= in_data;
		end
	end

endmodule

`default_nettype wire

// File: design/conv_window.sv
`timescale 1ns/1ps
`default_nettype none

module conv_window #(
	parameter int MAX_IMG = conv_pkg::MAX_IMG_DEFAULT,
	localparam int ADDR_W = $clog2(MAX_IMG * MAX_IMG)
) (
	input  logic clk,
	input  logic rst_n,
	input  logic wr_en,
	input  logic [ADDR_W-1:0] wr_addr,
	input  conv_pkg::pix_t in_data,
	input  logic scan_en,
	input  conv_pkg::size_t scan_row,
	input  conv_pkg::size_t scan_col,
	input  conv_pkg::size_t img_size,
	input  logic pad_sel,
	output logic win_valid,
	output conv_pkg::pix_t [conv_pkg::K-1:0][conv_pkg::K-1:0] win
);

	import conv_pkg::*;

	// row-major, stride MAX_IMG
	pix_t frame [MAX_IMG * MAX_IMG];
	pix_t [K-1:0][K-1:0] win_nxt;

	// nearest edge for replicate padding
	function automatic int clamp_coord(input int v, input int n);
		if (v < 0) begin
			return 0;
		end
		if (v >= n) begin
			return n - 1;
		end
		return v;
	endfunction

	// ----------------------------------------
	// frame store
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (wr_en) begin
			frame[wr_addr] <= in_data;
		end
	end

	// ----------------------------------------
	// padded 3x3 neighbourhood
	// ----------------------------------------
	always_comb begin
		int row_i;
		int col_i;
		int rd_addr;
		int n;
		logic outside;
		n = int'(img_size);
		for (int r = 0; r < K; r++) begin
			for (int c = 0; c < K; c++) begin
				row_i = int'(scan_row) + r - 1;
				col_i = int'(scan_col) + c - 1;
				outside = (row_i < 0) || (row_i >= n) || (col_i < 0) || (col_i >= n);
				rd_addr = clamp_coord(row_i, n) * MAX_IMG + clamp_coord(col_i, n);
				// zero mode drops anything past the border
				if (outside && !pad_sel) begin
					win_nxt[r][c] = '0;
				end else begin
					win_nxt[r][c] = frame[rd_addr];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win_valid <= 1'b0;
		end else begin
			win_valid <= scan_en;
		end
	end

	always_ff @(posedge clk) begin
		if (scan_en) begin
			win <= win_nxt;
		end
	end

endmodule

`default_nettype wire

// File: design/conv_row_mac.sv
`timescale 1ns/1ps
`default_nettype none

module conv_row_mac (
	input  logic clk,
	input  logic rst_n,
	input  logic win_valid,
	input  conv_pkg::pix_t [conv_pkg::K-1:0] pix_row,
	input  conv_pkg::coef_t [conv_pkg::K-1:0] coef_row,
	output logic row_valid,
	output conv_pkg::row_sum_t row_sum
);

	import conv_pkg::*;

	prod_t [K-1:0] prod;
	logic prod_valid;

	// stage 1, one product per column
	always_ff @(posedge clk) begin
		if (win_valid) begin
			for (int i = 0; i < K; i++) begin
				prod[i] <= pix_row[i] * coef_row[i];
			end
		end
	end

	// stage 2
	always_ff @(posedge clk) begin
		if (prod_valid) begin
			row_sum <= prod[0] + prod[1] + prod[2];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
			row_valid <= 1'b0;
		end else begin
			prod_valid <= win_valid;
			row_valid <= prod_valid;
		end
	end

endmodule

`default_nettype wire

// File: design/conv_reduce_act.sv
`timescale 1ns/1ps
`default_nettype none

module conv_reduce_act (
	input  logic clk,
	input  logic rst_n,
	input  logic row_valid,
	input  conv_pkg::row_sum_t [conv_pkg::K-1:0] row_sum,
	input  logic act_sel,
	output logic out_valid,
	output conv_pkg::result_t out_data
);

	import conv_pkg::*;

	acc_t acc;
	logic acc_valid;
	result_t act_val;

	// ----------------------------------------
	// window sum
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (row_valid) begin
			acc <= row_sum[0] + row_sum[1] + row_sum[2];
		end
	end

	// ----------------------------------------
	// activation and saturation
	// ----------------------------------------
	always_comb begin
		if (acc >= 0) begin
			if (acc > SAT_MAX) begin
				act_val = result_t'(SAT_MAX);
			end else begin
				act_val = acc[15:0];
			end
		end else if (act_sel) begin
			// signed divide truncates toward zero, always fits 16 bits
			act_val = result_t'(acc / LEAK_DIV);
		end else begin
			act_val = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_valid <= 1'b0;
			out_valid <= 1'b0;
			out_data <= '0;
		end else begin
			acc_valid <= row_valid;
			out_valid <= acc_valid;
			// idle bus reads as zero
			out_data <= acc_valid ? act_val : '0;
		end
	end

endmodule

`default_nettype wire

// File: design/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top #(
	parameter int MAX_IMG = conv_pkg::MAX_IMG_DEFAULT
) (
	input  logic clk,
	input  logic rst_n,
	input  logic filter_valid,
	input  logic image_valid,
	input  conv_pkg::size_t image_size,
	input  logic pad_mode,
	input  logic act_mode,
	input  conv_pkg::pix_t in_data,
	output logic out_valid,
	output conv_pkg::result_t out_data
);

	import conv_pkg::*;

	localparam int ADDR_W = $clog2(MAX_IMG * MAX_IMG);

	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic scan_en;
	size_t scan_row;
	size_t scan_col;
	coef_t [K-1:0][K-1:0] row_coef;
	size_t img_size;
	logic pad_sel;
	logic act_sel;
	logic win_valid;
	pix_t [K-1:0][K-1:0] win;
	logic [K-1:0] row_valid;
	row_sum_t [K-1:0] row_sum;

	conv_ctrl #(.MAX_IMG(MAX_IMG)) i_conv_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.filter_valid(filter_valid),
		.image_valid(image_valid),
		.image_size(image_size),
		.pad_mode(pad_mode),
		.act_mode(act_mode),
		.in_data(in_data),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.scan_en(scan_en),
		.scan_row(scan_row),
		.scan_col(scan_col),
		.row_coef(row_coef),
		.img_size(img_size),
		.pad_sel(pad_sel),
		.act_sel(act_sel)
	);

	conv_window #(.MAX_IMG(MAX_IMG)) i_conv_window (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.in_data(in_data),
		.scan_en(scan_en),
		.scan_row(scan_row),
		.scan_col(scan_col),
		.img_size(img_size),
		.pad_sel(pad_sel),
		.win_valid(win_valid),
		.win(win)
	);

	// one unit per kernel row
	for (genvar g = 0; g < K; g++) begin : g_row
		conv_row_mac i_conv_row_mac (
			.clk(clk),
			.rst_n(rst_n),
			.win_valid(win_valid),
			.pix_row(win[g]),
			.coef_row(row_coef[g]),
			.row_valid(row_valid[g]),
			.row_sum(row_sum[g])
		);
	end

	// rows run in lockstep, row 0 strobe stands for all
	conv_reduce_act i_conv_reduce_act (
		.clk(clk),
		.rst_n(rst_n),
		.row_valid(row_valid[0]),
		.row_sum(row_sum),
		.act_sel(act_sel),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

`default_nettype wire

// File: bench/conv_properties.sv
`timescale 1ns/1ps
`default_nettype none

module conv_properties (
	input  logic clk,
	input  logic rst_n,
	input  logic filter_valid,
	input  logic image_valid,
	input  logic out_valid,
	input  conv_pkg::result_t out_data
);

	int fails = 0;

	// idle output bus
	a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> out_data == '0)
	else begin
		fails++;
		$error("out_data is nonzero while out_valid is low");
	end

	a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(filter_valid && image_valid))
	else begin
		fails++;
		$error("filter_valid and image_valid are high together");
	end

	// results never overlap an incoming image
	a_out_vs_image: assert property (@(posedge clk) disable iff (!rst_n)
		image_valid |-> !out_valid)
	else begin
		fails++;
		$error("out_valid is high while image_valid is high");
	end

endmodule

bind conv_top conv_properties i_conv_properties (
	.clk(clk),
	.rst_n(rst_n),
	.filter_valid(filter_valid),
	.image_valid(image_valid),
	.out_valid(out_valid),
	.out_data(out_data)
);

`default_nettype wire

// File: bench/conv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tb;

	import conv_pkg::*;

	logic clk;
	logic rst_n;
	logic filter_valid;
	logic image_valid;
	size_t image_size;
	logic pad_mode;
	logic act_mode;
	pix_t in_data;
	logic out_valid;
	result_t out_data;

	int kern [9];
	int img [64];
	int cur_n;
	int cur_pad;
	int cur_act;
	int exp_q [$];
	int len_q [$];
	int value_errors = 0;
	int count_errors = 0;
	int timeouts = 0;
	int since_pixel = 1000;
	int run_len = 0;
	int exp_val;
	int exp_len;
	logic out_prev = 1'b0;

	conv_top #(.MAX_IMG(MAX_IMG_DEFAULT)) i_conv_top (
		.clk(clk),
		.rst_n(rst_n),
		.filter_valid(filter_valid),
		.image_valid(image_valid),
		.image_size(image_size),
		.pad_mode(pad_mode),
		.act_mode(act_mode),
		.in_data(in_data),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic int expected_at(input int r, input int c);
		int acc;
		int rr;
		int cc;
		int px;
		acc = 0;
		for (int dr = -1; dr <= 1; dr++) begin
			for (int dc = -1; dc <= 1; dc++) begin
				rr = r + dr;
				cc = c + dc;
				if (rr < 0 || rr >= cur_n || cc < 0 || cc >= cur_n) begin
					if (cur_pad == 0) begin
						px = 0;
					end else begin
						rr = (rr < 0) ? 0 : ((rr >= cur_n) ? cur_n - 1 : rr);
						cc = (cc < 0) ? 0 : ((cc >= cur_n) ? cur_n - 1 : cc);
						px = img[rr * cur_n + cc];
					end
				end else begin
					px = img[rr * cur_n + cc];
				end
				acc += px * kern[(dr + 1) * 3 + dc + 1];
			end
		end
		if (acc >= 0) begin
			return (acc > 32767) ? 32767 : acc;
		end
		// int division already truncates toward zero
		return cur_act ? acc / 10 : 0;
	endfunction

	// mode 0 random, 1 all 127, 2 negative kernel with non-negative pixels
	task automatic fill_data(input int n, input int mode);
		for (int i = 0; i < 9; i++) begin
			kern[i] = (mode == 0) ? int'($urandom_range(255)) - 128 :
				(mode == 1) ? 127 : -int'($urandom_range(128, 1));
		end
		for (int i = 0; i < n * n; i++) begin
			img[i] = (mode == 0) ? int'($urandom_range(255)) - 128 :
				(mode == 1) ? 127 : int'($urandom_range(127));
		end
	endtask

	task automatic run_image(input int n, input int pad, input int act);
		int cycles;
		cur_n = n;
		cur_pad = pad;
		cur_act = act;
		for (int i = 0; i < 9; i++) begin
			@(posedge clk);
			#1;
			filter_valid = 1'b1;
			in_data = pix_t'(kern[i]);
			image_size = size_t'(n);
			pad_mode = pad[0];
			act_mode = act[0];
		end
		@(posedge clk);
		#1;
		filter_valid = 1'b0;
		repeat (4) @(posedge clk);
		for (int i = 0; i < n * n; i++) begin
			exp_q.push_back(expected_at(i / n, i % n));
		end
		len_q.push_back(n * n);
		for (int i = 0; i < n * n; i++) begin
			@(posedge clk);
			#1;
			image_valid = 1'b1;
			in_data = pix_t'(img[i]);
		end
		@(posedge clk);
		#1;
		image_valid = 1'b0;
		cycles = 0;
		while ((exp_q.size() != 0 || len_q.size() != 0) && cycles < 400) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_q.size() != 0 || len_q.size() != 0) begin
			$display("timeout: the outputs of a %0dx%0d image did not finish", n, n);
			timeouts++;
			exp_q.delete();
			len_q.delete();
		end
	endtask

	// ----------------------------------------
	// output monitor
	// ----------------------------------------
	always @(posedge clk) begin
		if (rst_n) begin
			since_pixel = image_valid ? 0 : since_pixel + 1;
			if (out_valid) begin
				if (!out_prev) begin
					assert (since_pixel == 6) else begin
						count_errors++;
						$display("FAIL out_valid latency expected %h got %h", 6, since_pixel);
					end
				end
				run_len++;
				if (exp_q.size() == 0) begin
					count_errors++;
					$display("out_valid went high with no result expected");
				end else begin
					exp_val = exp_q.pop_front();
					assert (int'(out_data) == exp_val) else begin
						value_errors++;
						$display("FAIL out_data expected %h got %h", 16'(exp_val), out_data);
					end
				end
			end else if (out_prev) begin
				exp_len = (len_q.size() != 0) ? len_q.pop_front() : 0;
				assert (run_len == exp_len) else begin
					count_errors++;
					$display("FAIL out_valid run length expected %h got %h", exp_len, run_len);
				end
				run_len = 0;
			end
			out_prev = out_valid;
		end
	end

	initial begin
		void'($urandom(85859));
		rst_n = 1'b0;
		filter_valid = 1'b0;
		image_valid = 1'b0;
		image_size = size_t'(3);
		pad_mode = 1'b0;
		act_mode = 1'b0;
		in_data = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// out_valid must stay quiet before any image
		repeat (10) @(posedge clk);
		fill_data(5, 0);
		run_image(5, 0, 0);
		run_image(5, 1, 0);
		fill_data(3, 0);
		run_image(3, 1, 1);
		fill_data(8, 0);
		run_image(8, 0, 1);
		fill_data(8, 1);
		run_image(8, 0, 0);
		fill_data(6, 2);
		run_image(6, 1, 0);
		run_image(6, 1, 1);
		// fresh kernel and settings on the same image
		for (int i = 0; i < 9; i++) begin
			kern[i] = int'($urandom_range(255)) - 128;
		end
		run_image(6, 0, 1);
		repeat (5) @(posedge clk);
		$display("errors: value=%0d count=%0d timeout=%0d assert=%0d", value_errors,
			count_errors, timeouts, i_conv_top.i_conv_properties.fails);
		if (value_errors + count_errors + timeouts + i_conv_top.i_conv_properties.fails == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
design/conv_pkg.sv
design/conv_ctrl.sv
design/conv_window.sv
design/conv_row_mac.sv
design/conv_reduce_act.sv
design/conv_top.sv
bench/conv_properties.sv
bench/conv_tb.sv

// File: Bender.yml
package:
  name: conv_engine

sources:
  - files:
      - design/conv_pkg.sv
      - design/conv_ctrl.sv
      - design/conv_window.sv
      - design/conv_row_mac.sv
      - design/conv_reduce_act.sv
      - design/conv_top.sv
  - target: test
    files:
      - bench/conv_properties.sv
      - bench/conv_tb.sv
